// ==== verilog/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

    localparam int dataWidth    = 32; // XLEN
    localparam int regAddrWidth = 5;  // rs1/rs2/rd field width

    // Supported major opcodes
    localparam logic [6:0] opOp    = 7'b0110011; // Register-register ALU
    localparam logic [6:0] opOpImm = 7'b0010011; // Register-immediate ALU

    // funct3 codes, shared by both classes
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [6:0] f7Base = 7'b0000000; // Normal form
    localparam logic [6:0] f7Alt  = 7'b0100000; // SUB and SRA

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOpE;

    typedef struct packed {
        logic [6:0]              funct7;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } rTypeS;

    typedef struct packed {
        logic [11:0]             imm12; // Shift forms keep funct7 in [11:5]
        logic [regAddrWidth-1:0] rs1;
        logic [2:0]              funct3;
        logic [regAddrWidth-1:0] rd;
        logic [6:0]              opcode;
    } iTypeS;

    // One word, two layouts
    typedef union packed {
        rTypeS rType;
        iTypeS iType;
    } instrU;

endpackage

`default_nettype wire

// ==== verilog/decodeIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
    import rvCorePkg::*;

    logic                    valid;   // Legal instruction this cycle
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;     // Zero for immediate forms
    logic [regAddrWidth-1:0] rd;
    aluOpE                   aluOp;
    logic                    useImm;  // Second operand from imm
    logic [dataWidth-1:0]    imm;     // Already sign-extended
    logic                    writeEn; // Result goes to a nonzero rd

    // Decoder side
    modport dec (
        output valid, rs1, rs2, rd, aluOp, useImm, imm, writeEn
    );

    // Execute side
    modport exec (
        input valid, rs1, rs2, rd, aluOp, useImm, imm, writeEn
    );

endinterface

`default_nettype wire

// ==== verilog/intAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input  rvCorePkg::aluOpE                  aluOp,
    input  logic [rvCorePkg::dataWidth-1:0]   opA,
    input  logic [rvCorePkg::dataWidth-1:0]   opB,
    output logic [rvCorePkg::dataWidth-1:0]   result
);
    import rvCorePkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0]; // RV32 uses five bits only
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluSll:  result = opA << shamt;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, ltSigned};
            aluSltu: result = {{(dataWidth-1){1'b0}}, ltUnsigned};
            aluXor:  result = opA ^ opB;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $unsigned($signed(opA) >>> shamt); // Sign fill
            aluOr:   result = opA | opB;
            aluAnd:  result = opA & opB;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder #(
    parameter int regCount = 32 // 32 for RV32I, 16 for RV32E
) (
    input  logic             instrValid,
    input  rvCorePkg::instrU instr,
    output logic             illegalInstr,
    decodeIf.dec             dec
);
    import rvCorePkg::*;

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    logic [11:0]             imm12;
    logic                    isOp;    // R-type view applies
    logic                    isOpImm; // I-type view applies
    logic                    encOk;
    logic                    rangeOk;
    logic                    legal;
    logic                    altForm; // Selects SUB or SRA
    aluOpE                   aluOp;

    // Common fields sit at the same bits in both views
    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;
    assign rs1    = instr.rType.rs1;
    assign rd     = instr.rType.rd;
    assign rs2    = instr.rType.rs2;    // Only meaningful for R-type
    assign imm12  = instr.iType.imm12;  // Only meaningful for I-type

    assign isOp    = (opcode == opOp);
    assign isOpImm = (opcode == opOpImm);

    // funct7 legality per class
    always_comb begin
        encOk   = 1'b0;
        altForm = 1'b0;
        if (isOp) begin
            altForm = (instr.rType.funct7 == f7Alt);
            encOk   = (instr.rType.funct7 == f7Base) ||
                      (altForm && (funct3 == f3AddSub || funct3 == f3SrlSra));
        end else if (isOpImm) begin
            case (funct3)
                f3Sll:    encOk = (imm12[11:5] == f7Base);
                f3SrlSra: begin
                    altForm = (imm12[11:5] == f7Alt); // SRAI
                    encOk   = (imm12[11:5] == f7Base) || altForm;
                end
                default:  encOk = 1'b1; // Any immediate
            endcase
        end
    end

    // ALU op straight from funct3
    always_comb begin
        case (funct3)
            f3AddSub: aluOp = altForm ? aluSub : aluAdd;
            f3Sll:    aluOp = aluSll;
            f3Slt:    aluOp = aluSlt;
            f3Sltu:   aluOp = aluSltu;
            f3Xor:    aluOp = aluXor;
            f3SrlSra: aluOp = altForm ? aluSra : aluSrl;
            f3Or:     aluOp = aluOr;
            default:  aluOp = aluAnd;
        endcase
    end

    // RV32E has no x16..x31
    assign rangeOk = (int'(rs1) < regCount) && (int'(rd) < regCount) &&
                     (!isOp || int'(rs2) < regCount);
    assign legal   = encOk && rangeOk;

    assign illegalInstr = instrValid && !legal;

    assign dec.valid   = instrValid && legal;
    assign dec.rs1     = rs1;
    assign dec.rs2     = isOp ? rs2 : '0; // Keep unused read port quiet
    assign dec.rd      = rd;
    assign dec.aluOp   = aluOp;
    assign dec.useImm  = isOpImm;
    assign dec.writeEn = legal && (rd != '0); // x0 target is a no-op

    // Shift amount from low five bits, else sign-extend
    assign dec.imm = (funct3 == f3Sll || funct3 == f3SrlSra) ?
                     {{(dataWidth-5){1'b0}}, imm12[4:0]} :
                     {{(dataWidth-12){imm12[11]}}, imm12};

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile #(
    parameter int regCount = 32
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [rvCorePkg::regAddrWidth-1:0]  rs1Addr,
    input  logic [rvCorePkg::regAddrWidth-1:0]  rs2Addr,
    input  logic                                wbValid,
    input  logic [rvCorePkg::regAddrWidth-1:0]  wbRd,
    input  logic [rvCorePkg::dataWidth-1:0]     wbData,
    input  logic                                trigger,
    input  logic [rvCorePkg::regAddrWidth-1:0]  dbgAddr,
    output logic [rvCorePkg::dataWidth-1:0]     rdData1,
    output logic [rvCorePkg::dataWidth-1:0]     rdData2,
    output logic [rvCorePkg::dataWidth-1:0]     dbgData,
    output logic [rvCorePkg::dataWidth-1:0]     a0
);
    import rvCorePkg::*;

    localparam int t0Idx = 5;  // Trigger target
    localparam int a0Idx = 10; // Return value register

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wbValid && wbRd != '0 && int'(wbRd) < regCount) begin
                regs[wbRd] <= wbData;
            end
            if (trigger) begin
                regs[t0Idx] <= {{(dataWidth-1){1'b0}}, 1'b1}; // Wins over commit
            end
            regs[0] <= '0; // Hardwired zero, last word
        end
    end

    // Combinational reads, unknown indices read zero
    assign rdData1 = (int'(rs1Addr) < regCount) ? regs[rs1Addr] : '0;
    assign rdData2 = (int'(rs2Addr) < regCount) ? regs[rs2Addr] : '0;
    assign dbgData = (int'(dbgAddr) < regCount) ? regs[dbgAddr] : '0;

    assign a0 = regs[a0Idx];

endmodule

`default_nettype wire

// ==== verilog/execStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStage (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [rvCorePkg::dataWidth-1:0]     rdData1,
    input  logic [rvCorePkg::dataWidth-1:0]     rdData2,
    output logic [rvCorePkg::regAddrWidth-1:0]  rs1Addr,
    output logic [rvCorePkg::regAddrWidth-1:0]  rs2Addr,
    output logic                                wbValid,
    output logic [rvCorePkg::regAddrWidth-1:0]  wbRd,
    output logic [rvCorePkg::dataWidth-1:0]     wbData,
    decodeIf.exec                               dec
);
    import rvCorePkg::*;

    logic                 fwdA;      // rs1 hits pending writeback
    logic                 fwdB;      // rs2 hits pending writeback
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;
    logic                 capture;

    assign rs1Addr = dec.rs1; // Register file read addresses
    assign rs2Addr = dec.rs2;

    // Pending result not yet in the array
    assign fwdA = wbValid && (wbRd != '0) && (wbRd == dec.rs1);
    assign fwdB = wbValid && (wbRd != '0) && (wbRd == dec.rs2);

    assign opA = fwdA ? wbData : rdData1;
    assign opB = dec.useImm ? dec.imm : (fwdB ? wbData : rdData2);

    intAlu u_alu (
        .aluOp  (dec.aluOp),
        .opA    (opA),
        .opB    (opB),
        .result (aluResult)
    );

    assign capture = dec.valid && dec.writeEn;

    // Writeback valid flag
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= capture;
        end
    end

    // Payload only moves on a writing instruction
    always_ff @(posedge clk) begin
        if (capture) begin
            wbRd   <= dec.rd;
            wbData <= aluResult;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rvExecCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvExecCore #(
    parameter int regCount = 32 // 16 gives RV32E
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                instrValid,
    input  logic [31:0]                         instr,
    input  logic                                trigger,
    input  logic [rvCorePkg::regAddrWidth-1:0]  dbgAddr,
    output logic                                illegalInstr,
    output logic [rvCorePkg::dataWidth-1:0]     dbgData,
    output logic [rvCorePkg::dataWidth-1:0]     a0
);
    import rvCorePkg::*;

    logic [regAddrWidth-1:0] rs1Addr;
    logic [regAddrWidth-1:0] rs2Addr;
    logic [dataWidth-1:0]    rdData1;
    logic [dataWidth-1:0]    rdData2;
    logic                    wbValid;  // Writeback stage occupied
    logic [regAddrWidth-1:0] wbRd;
    logic [dataWidth-1:0]    wbData;

    decodeIf decBus ();

    instrDecoder #(
        .regCount (regCount)
    ) u_decoder (
        .instrValid   (instrValid),
        .instr        (instr),       // Raw word into union view
        .illegalInstr (illegalInstr),
        .dec          (decBus.dec)
    );

    execStage u_exec (
        .clk     (clk),
        .rstN    (rstN),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData),
        .dec     (decBus.exec)
    );

    regFile #(
        .regCount (regCount)
    ) u_regs (
        .clk     (clk),
        .rstN    (rstN),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData),
        .trigger (trigger),
        .dbgAddr (dbgAddr),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .dbgData (dbgData),
        .a0      (a0)
    );

endmodule

`default_nettype wire

// ==== test/rvExecCoreSva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvExecCoreSva (
    input logic        clk,
    input logic        rstN,
    input logic        instrValid,
    input logic [31:0] instr,
    input logic        illegalInstr,
    input logic        wbValid,   // Internal writeback flag
    input logic [4:0]  dbgAddr,
    input logic [31:0] dbgData
);

    // x0 never holds anything
    zeroReg: assert property (@(posedge clk) disable iff (!rstN)
        (dbgAddr == 5'd0) |-> (dbgData == 32'd0))
        else $error("x0 read back nonzero on the debug port");

    // Illegal word came with valid and never reaches writeback
    illegalNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        illegalInstr |=> ($past(instrValid) && !wbValid))
        else $error("illegalInstr without instrValid or illegal word written back");

    // Legal op with nonzero rd lands in writeback one cycle later
    wbFollows: assert property (@(posedge clk) disable iff (!rstN)
        (instrValid && !illegalInstr && instr[11:7] != 5'd0) |=> wbValid)
        else $error("writeback slot not filled after a writing instruction");

endmodule

bind rvExecCore rvExecCoreSva u_sva (
    .clk          (clk),
    .rstN         (rstN),
    .instrValid   (instrValid),
    .instr        (instr),
    .illegalInstr (illegalInstr),
    .wbValid      (wbValid),
    .dbgAddr      (dbgAddr),
    .dbgData      (dbgData)
);

`default_nettype wire

// ==== test/tbRvExecCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRvExecCore;

    localparam logic [6:0] opR = 7'b0110011; // Register-register class
    localparam logic [6:0] opI = 7'b0010011; // Register-immediate class

    // Run budget in cycles
    localparam int checkCycles = 35;          // 32 debug reads, flush, slack
    localparam int numChecks   = 8;           // compareRegs calls
    localparam int directed    = 47;          // Directed instructions and idles
    localparam int randomWorst = 200 * 5;     // Each random op plus up to four idles
    localparam int maxCycles   = 8 + numChecks * checkCycles + directed + randomWorst + 200;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        trigger;
    logic [4:0]  dbgAddr;
    logic        illegalInstr;
    logic [31:0] dbgData;
    logic [31:0] a0;

    logic [31:0] model [32];  // Reference register array
    logic        pendValid;   // Model of the writeback slot
    logic [4:0]  pendRd;
    logic [31:0] pendData;
    logic [31:0] rngState;
    int          errCount;
    int          checkCount;
    int          cycleCnt;

    rvExecCore #(
        .regCount (32)
    ) u_dut (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .trigger      (trigger),
        .dbgAddr      (dbgAddr),
        .illegalInstr (illegalInstr),
        .dbgData      (dbgData),
        .a0           (a0)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Hard stop if a test never returns
    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= maxCycles) begin
            $display("Timeout after %0d cycles, tests did not finish", cycleCnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opI};
    endfunction

    // Supported encodings per the RV32I base spec
    function automatic logic legalWord(input logic [31:0] w);
        case (w[6:0])
            opR: return (w[31:25] == 7'h00) ||
                        (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
            opI: begin
                if (w[14:12] == 3'd1) return w[31:25] == 7'h00;    // SLLI
                if (w[14:12] == 3'd5) return w[31:25] == 7'h00 || w[31:25] == 7'h20;
                return 1'b1;
            end
            default: return 1'b0;
        endcase
    endfunction

    // Expected ALU result with shifts by five bits of the second operand
    function automatic logic [31:0] refResult(input logic [31:0] w, input logic [31:0] a,
                                              input logic [31:0] rs2Val);
        logic [31:0] b;
        b = (w[6:0] == opI) ? {{20{w[31]}}, w[31:20]} : rs2Val;
        case (w[14:12])
            3'd0:    return (w[6:0] == opR && w[30]) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, ($signed(a) < $signed(b))};
            3'd3:    return {31'd0, (a < b)};
            3'd4:    return a ^ b;
            3'd5:    return w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // One input cycle; the model steps the edge that samples it
    task automatic stepCycle(input logic v, input logic [31:0] w, input logic t);
        logic [31:0] res;
        logic        expIll;
        @(posedge clk);
        instrValid <= v;
        instr      <= w;
        trigger    <= t;
        expIll = v && !legalWord(w);
        if (pendValid) model[pendRd] = pendData; // Commit of the older op
        res = refResult(w, model[w[19:15]], model[w[24:20]]); // Sees it as forwarded
        if (t) model[5] = 32'd1;                 // Trigger beats commit
        model[0]  = 32'd0;
        pendValid = v && legalWord(w) && (w[11:7] != 5'd0);
        pendRd    = w[11:7];
        pendData  = res;
        @(negedge clk);
        expectEq("illegalInstr", {31'd0, illegalInstr}, {31'd0, expIll});
    endtask

    task automatic issue(input logic [31:0] w);
        stepCycle(1'b1, w, 1'b0);
    endtask

    task automatic flushPipe();
        stepCycle(1'b0, 32'd0, 1'b0);
        stepCycle(1'b0, 32'd0, 1'b0); // Second edge commits
    endtask

    // Whole register file over the debug port
    task automatic compareRegs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            dbgAddr <= 5'(i);
            @(negedge clk);
            expectEq($sformatf("dbgData[x%0d]", i), dbgData, model[i]);
        end
        expectEq("a0", a0, model[10]);
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        $display("%-10s %s", name, (errCount == errsBefore) ? "passed" : "FAILED");
    endtask

    task automatic testReset();
        int errs0;
        errs0 = errCount;
        compareRegs();                       // All zero out of reset
        issue(encI(12'd5, 5'd0, 3'd0, 5'd0)); // ADDI x0 is dropped
        flushPipe();
        compareRegs();
        reportTest("reset", errs0);
    endtask

    task automatic testRegOps();
        int errs0;
        errs0 = errCount;
        issue(encI(12'hFF9, 5'd0, 3'd0, 5'd1)); // x1 = -7
        issue(encI(12'h5A3, 5'd0, 3'd0, 5'd2));
        issue(encI(12'h003, 5'd0, 3'd0, 5'd3));
        issue(encR(7'h00, 5'd3, 5'd1, 3'd0, 5'd4));  // ADD, rs2 forwarded
        issue(encR(7'h20, 5'd1, 5'd4, 3'd0, 5'd5));  // SUB, rs1 forwarded
        issue(encR(7'h00, 5'd3, 5'd5, 3'd1, 5'd6));  // SLL
        issue(encR(7'h00, 5'd6, 5'd1, 3'd2, 5'd7));  // SLT, rs2 forwarded
        issue(encR(7'h00, 5'd1, 5'd7, 3'd3, 5'd8));  // SLTU
        issue(encR(7'h00, 5'd2, 5'd8, 3'd4, 5'd9));  // XOR
        issue(encR(7'h00, 5'd9, 5'd1, 3'd5, 5'd10)); // SRL
        issue(encR(7'h20, 5'd10, 5'd1, 3'd5, 5'd11)); // SRA of a negative
        issue(encR(7'h00, 5'd2, 5'd11, 3'd6, 5'd12)); // OR
        issue(encR(7'h00, 5'd4, 5'd12, 3'd7, 5'd13)); // AND
        flushPipe();
        compareRegs();
        reportTest("regOps", errs0);
    endtask

    task automatic testImmOps();
        int errs0;
        errs0 = errCount;
        issue(encI(12'hFFF, 5'd1, 3'd0, 5'd14)); // ADDI -1
        issue(encI(12'hFFA, 5'd1, 3'd2, 5'd15)); // SLTI -6
        issue(encI(12'hFFF, 5'd2, 3'd3, 5'd16)); // SLTIU vs all ones
        issue(encI(12'hFFF, 5'd1, 3'd4, 5'd17));
        issue(encI(12'h800, 5'd2, 3'd6, 5'd18)); // ORI -2048
        issue(encI(12'hFF0, 5'd1, 3'd7, 5'd19));
        issue(encI(12'h000, 5'd1, 3'd1, 5'd20)); // Shift by 0
        issue(encI(12'h01F, 5'd1, 3'd1, 5'd21));
        issue(encI(12'h001, 5'd1, 3'd5, 5'd22));
        issue(encI(12'h01F, 5'd1, 3'd5, 5'd23));
        issue(encI(12'h401, 5'd1, 3'd5, 5'd24)); // SRAI 1 on negative
        issue(encI(12'h41F, 5'd1, 3'd5, 5'd25));
        issue(encI(12'h400, 5'd1, 3'd5, 5'd26));
        flushPipe();
        compareRegs();
        reportTest("immOps", errs0);
    endtask

    task automatic testTrigger();
        int errs0;
        errs0 = errCount;
        stepCycle(1'b0, 32'd0, 1'b1);           // Lone pulse
        flushPipe();
        compareRegs();
        issue(encI(12'd77, 5'd0, 3'd0, 5'd5));
        stepCycle(1'b0, 32'd0, 1'b1);           // Lands on the x5 commit edge
        issue(encI(12'h123, 5'd0, 3'd0, 5'd10));
        issue(encI(12'h001, 5'd10, 3'd0, 5'd10));
        flushPipe();
        compareRegs();
        reportTest("trigger", errs0);
    endtask

    task automatic testIllegal();
        int errs0;
        errs0 = errCount;
        issue({12'h001, 5'd1, 3'd0, 5'd27, 7'b0000011}); // Load opcode
        issue(encR(7'h21, 5'd2, 5'd1, 3'd0, 5'd28));     // SUB, bad funct7
        issue({25'h1ABCDEF, 7'b1111111});
        flushPipe();
        compareRegs();
        reportTest("illegal", errs0);
    endtask

    task automatic testRandom();
        int          errs0;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        errs0 = errCount;
        for (int n = 0; n < 200; n++) begin
            rngState = xorshift(rngState);
            r  = rngState;
            f3 = r[14:12];
            if (r[0]) begin
                f7 = (r[1] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                issue(encR(f7, r[24:20], r[19:15], f3, r[11:7]));
            end else begin
                imm = r[31:20];
                if (f3 == 3'd1) imm[11:5] = 7'h00;
                if (f3 == 3'd5) imm[11:5] = r[1] ? 7'h20 : 7'h00;
                issue(encI(imm, r[19:15], f3, r[11:7]));
            end
            if (r[3:2] == 2'b00) begin
                repeat (int'(r[5:4]) + 1) stepCycle(1'b0, 32'd0, 1'b0); // Bubbles
            end
        end
        flushPipe();
        compareRegs();
        reportTest("random", errs0);
    endtask

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = 32'd0;
        trigger    = 1'b0;
        dbgAddr    = 5'd0;
        pendValid  = 1'b0;
        pendRd     = 5'd0;
        pendData   = 32'd0;
        rngState   = 32'd91768;
        errCount   = 0;
        checkCount = 0;
        cycleCnt   = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 32'd0;
        end
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        testReset();
        testRegOps();
        testImmOps();
        testTrigger();
        testIllegal();
        testRandom();
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/rvCorePkg.sv
verilog/decodeIf.sv
verilog/intAlu.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/execStage.sv
verilog/rvExecCore.sv
test/rvExecCoreSva.sv
test/tbRvExecCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbRvExecCore
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
